// File: verilog/rep_consts.svh
//----------------------------------------
// Replicator constants
// Destination vector, priority, descriptor
// field widths and queue depth
//----------------------------------------

`ifndef REP_CONSTS_SVH
`define REP_CONSTS_SVH

// Destination vector
`define REP_NDEST 8
`define REP_DEST_NBITS 3

// Priority
`define REP_PRI_NBITS 2

// Descriptor fields
`define REP_BUF_PTR_NBITS 12
`define REP_LEN_NBITS 10
`define REP_PORT_NBITS 3

// Entries per queue, unicast and multicast alike
`define REP_FIFO_DEPTH 16

`endif

// File: verilog/rep_pkg.sv
//----------------------------------------
// Replicator types
// Vector, queue id, descriptor and queue
// entry layouts shared by all blocks
//----------------------------------------

`default_nettype none

`include "rep_consts.svh"

package rep_pkg;

	typedef logic [`REP_NDEST-1:0] dest_vec_t;
	typedef logic [`REP_DEST_NBITS-1:0] dest_t;
	typedef logic [`REP_DEST_NBITS:0] dest_count_t;	// 0 to REP_NDEST
	typedef logic [`REP_PRI_NBITS-1:0] pri_t;
	typedef logic [`REP_PRI_NBITS+`REP_DEST_NBITS-1:0] qid_t;	// {pri, dest}

	typedef struct packed {
		logic [`REP_BUF_PTR_NBITS-1:0] buf_ptr;
		logic [`REP_LEN_NBITS-1:0] len;
		logic [`REP_PORT_NBITS-1:0] src_port;
	} rep_desc_t;

	// One queue entry
	typedef struct packed {
		dest_vec_t vec;
		pri_t pri;
		dest_count_t count;
		rep_desc_t desc;
	} rep_item_t;

endpackage

`default_nettype wire

// File: verilog/rep_if.sv
//----------------------------------------
// Replicator internal buses
// Classifier to queue writes and queue
// head to fan-out handshake
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

interface rep_req_if;

	logic ucast_wr;
	logic mcast_wr;
	rep_pkg::rep_item_t item;
	logic ucast_full;
	logic mcast_full;

	modport src (
		output ucast_wr,
		output mcast_wr,
		output item,
		input ucast_full,
		input mcast_full
	);

	modport dst (
		input ucast_wr,
		input mcast_wr,
		input item,
		output ucast_full,
		output mcast_full
	);

endinterface

interface rep_item_if;

	logic valid;
	rep_pkg::rep_item_t item;
	logic take;	// Pops the offered entry

	modport src (output valid, output item, input take);

	modport dst (input valid, input item, output take);

endinterface

`default_nettype wire

// File: verilog/rep_fifo.sv
//----------------------------------------
// Request queue
// Circular buffer of queue entries, head
// entry shown on dout
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "rep_consts.svh"

module rep_fifo #(
	parameter int DEPTH = `REP_FIFO_DEPTH
) (
	input logic clk,
	input logic rst_n,
	input logic wr,
	input rep_pkg::rep_item_t din,
	input logic rd,
	output rep_pkg::rep_item_t dout,
	output logic empty,
	output logic full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	rep_pkg::rep_item_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
		return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk)
		if (wr)
			mem[wr_ptr] <= din;

	always_ff @(posedge clk or negedge rst_n)
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd)
				rd_ptr <= next_ptr(rd_ptr);
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end

	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CW'(DEPTH));

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full |-> !wr)
		else $error("write to a full queue");
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !rd)
		else $error("read from an empty queue");

endmodule

`default_nettype wire

// File: verilog/rep_enq_classifier.sv
//----------------------------------------
// Enqueue classifier
// Counts destinations and sends a request
// to a queue or to the discard port
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module rep_enq_classifier (
	input logic clk,
	input logic rst_n,
	input logic enq_req,
	input logic enq_discard,
	input logic enq_allow_mcast,
	input rep_pkg::dest_vec_t enq_vec,
	input rep_pkg::pri_t enq_pri,
	input rep_pkg::rep_desc_t enq_desc,
	rep_req_if.src req,
	output logic discard_req,
	output rep_pkg::rep_desc_t discard_desc
);

	logic req_d1;
	logic discard_d1;
	logic allow_mcast_d1;
	rep_pkg::dest_vec_t vec_d1;
	rep_pkg::pri_t pri_d1;
	rep_pkg::rep_desc_t desc_d1;

	rep_pkg::dest_count_t dest_count;
	logic to_ucast;
	logic to_mcast;
	logic discard_set;

	// Tree adder over the 8 destination bits
	function automatic rep_pkg::dest_count_t bit_sum(input rep_pkg::dest_vec_t v);
		logic [1:0] s2 [4];
		logic [2:0] s4 [2];
		for (int i = 0; i < 4; i++)
			s2[i] = {1'b0, v[2*i]} + {1'b0, v[2*i+1]};
		for (int i = 0; i < 2; i++)
			s4[i] = {1'b0, s2[2*i]} + {1'b0, s2[2*i+1]};
		return {1'b0, s4[0]} + {1'b0, s4[1]};
	endfunction

	always_ff @(posedge clk)
	begin
		discard_d1 <= enq_discard;
		allow_mcast_d1 <= enq_allow_mcast;
		vec_d1 <= enq_vec;
		pri_d1 <= enq_pri;
		desc_d1 <= enq_desc;
		if (discard_set)
			discard_desc <= desc_d1;
	end

	always_ff @(posedge clk or negedge rst_n)
		if (!rst_n)
		begin
			req_d1 <= 1'b0;
			discard_req <= 1'b0;
		end
		else
		begin
			req_d1 <= enq_req;
			discard_req <= discard_set;
		end

	assign dest_count = bit_sum(vec_d1);
	assign to_ucast = req_d1 & ~discard_d1 & (dest_count == rep_pkg::dest_count_t'(1));
	assign to_mcast = req_d1 & ~discard_d1 & (dest_count > rep_pkg::dest_count_t'(1))
		& allow_mcast_d1;

	assign req.ucast_wr = to_ucast & ~req.ucast_full;
	assign req.mcast_wr = to_mcast & ~req.mcast_full;
	assign req.item = '{vec: vec_d1, pri: pri_d1, count: dest_count, desc: desc_d1};

	assign discard_set = req_d1 & ~req.ucast_wr & ~req.mcast_wr;	// Rule or full queue

	a_known_req: assert property (@(posedge clk) disable iff (!rst_n)
		enq_req |-> !$isunknown({enq_discard, enq_allow_mcast, enq_vec, enq_pri}))
		else $error("request with unknown flags or destinations");

endmodule

`default_nettype wire

// File: verilog/rep_enq_queue.sv
//----------------------------------------
// Unicast and multicast queues
// Unicast head is offered first
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module rep_enq_queue (
	input logic clk,
	input logic rst_n,
	rep_req_if.dst req,
	rep_item_if.src head
);

	rep_pkg::rep_item_t ucast_dout;
	rep_pkg::rep_item_t mcast_dout;
	logic ucast_empty;
	logic mcast_empty;
	logic ucast_rd;
	logic mcast_rd;

	rep_fifo ucast_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr(req.ucast_wr),
		.din(req.item),
		.rd(ucast_rd),
		.dout(ucast_dout),
		.empty(ucast_empty),
		.full(req.ucast_full)
	);

	rep_fifo mcast_fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr(req.mcast_wr),
		.din(req.item),
		.rd(mcast_rd),
		.dout(mcast_dout),
		.empty(mcast_empty),
		.full(req.mcast_full)
	);

	assign head.valid = ~ucast_empty | ~mcast_empty;
	assign head.item = ucast_empty ? mcast_dout : ucast_dout;

	// Pop whichever queue was offered
	assign ucast_rd = head.take & ~ucast_empty;
	assign mcast_rd = head.take & ucast_empty;

endmodule

`default_nettype wire

// File: verilog/rep_fanout.sv
//----------------------------------------
// Fan-out stage
// Walks the destination vector low to high
// and emits one copy per cycle
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module rep_fanout (
	input logic clk,
	input logic rst_n,
	rep_item_if.dst head,
	output logic rep_enq_req,
	output logic rep_enq_ucast,
	output logic rep_enq_last,
	output rep_pkg::dest_t rep_enq_packet_id,
	output rep_pkg::qid_t rep_enq_qid,
	output rep_pkg::rep_desc_t rep_enq_desc
);

	logic busy;
	rep_pkg::dest_vec_t rem_vec;
	rep_pkg::pri_t held_pri;
	rep_pkg::rep_desc_t held_desc;
	rep_pkg::dest_count_t held_cnt;
	rep_pkg::dest_t copy_idx;

	rep_pkg::dest_vec_t cur_vec;
	rep_pkg::pri_t cur_pri;
	rep_pkg::rep_desc_t cur_desc;
	rep_pkg::dest_count_t cur_cnt;
	rep_pkg::dest_t cur_idx;
	rep_pkg::dest_t cur_dest;
	logic emit;
	logic last_now;

	// Lowest set bit of the vector
	function automatic rep_pkg::dest_t low_dest(input rep_pkg::dest_vec_t v);
		rep_pkg::dest_t d;
		d = '0;
		for (int i = $bits(v) - 1; i >= 0; i--)
			if (v[i])
				d = rep_pkg::dest_t'(i);
		return d;
	endfunction

	assign head.take = head.valid & ~busy;

	// A newly taken item yields its first copy in the same cycle
	assign cur_vec = head.take ? head.item.vec : rem_vec;
	assign cur_pri = head.take ? head.item.pri : held_pri;
	assign cur_desc = head.take ? head.item.desc : held_desc;
	assign cur_cnt = head.take ? head.item.count : held_cnt;
	assign cur_idx = head.take ? '0 : copy_idx;

	assign cur_dest = low_dest(cur_vec);
	assign emit = head.take | busy;
	assign last_now = ({1'b0, cur_idx} + 1'b1) == cur_cnt;

	always_ff @(posedge clk)
	begin
		if (emit)
		begin
			rem_vec <= cur_vec & ~(rep_pkg::dest_vec_t'(1) << cur_dest);
			held_pri <= cur_pri;
			held_desc <= cur_desc;
			held_cnt <= cur_cnt;
			copy_idx <= cur_idx + 1'b1;
			rep_enq_ucast <= (cur_cnt == rep_pkg::dest_count_t'(1));
			rep_enq_last <= last_now;
			rep_enq_packet_id <= cur_idx;
			rep_enq_qid <= {cur_pri, cur_dest};
			rep_enq_desc <= cur_desc;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
		if (!rst_n)
		begin
			busy <= 1'b0;
			rep_enq_req <= 1'b0;
		end
		else
		begin
			busy <= emit & ~last_now;	// Idle again while the last copy is out
			rep_enq_req <= emit;
		end

	// Count and vector of the held item must agree
	a_dest_left: assert property (@(posedge clk) disable iff (!rst_n)
		emit |-> (cur_vec != '0))
		else $error("copy due with no destination left");

endmodule

`default_nettype wire

// File: verilog/mcast_replicator.sv
//----------------------------------------
// Multicast enqueue replicator
// Classifier, queues and fan-out stage
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module mcast_replicator (
	input logic clk,
	input logic rst_n,
	input logic enq_req,
	input logic enq_discard,
	input logic enq_allow_mcast,
	input rep_pkg::dest_vec_t enq_vec,
	input rep_pkg::pri_t enq_pri,
	input rep_pkg::rep_desc_t enq_desc,
	output logic discard_req,
	output rep_pkg::rep_desc_t discard_desc,
	output logic rep_enq_req,
	output logic rep_enq_ucast,
	output logic rep_enq_last,
	output rep_pkg::dest_t rep_enq_packet_id,
	output rep_pkg::qid_t rep_enq_qid,
	output rep_pkg::rep_desc_t rep_enq_desc
);

	rep_req_if req_bus ();
	rep_item_if item_bus ();

	rep_enq_classifier classifier_i (
		.clk(clk),
		.rst_n(rst_n),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.req(req_bus),
		.discard_req(discard_req),
		.discard_desc(discard_desc)
	);

	rep_enq_queue queue_i (
		.clk(clk),
		.rst_n(rst_n),
		.req(req_bus),
		.head(item_bus)
	);

	rep_fanout fanout_i (
		.clk(clk),
		.rst_n(rst_n),
		.head(item_bus),
		.rep_enq_req(rep_enq_req),
		.rep_enq_ucast(rep_enq_ucast),
		.rep_enq_last(rep_enq_last),
		.rep_enq_packet_id(rep_enq_packet_id),
		.rep_enq_qid(rep_enq_qid),
		.rep_enq_desc(rep_enq_desc)
	);

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
//----------------------------------------
// Testbench clock and reset
// Free running clock, reset held low for
// a fixed number of cycles
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_mcast_replicator.sv
//----------------------------------------
// Replicator testbench
// Directed, random and burst traffic
// checked against per-class scoreboards
//----------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "rep_consts.svh"

module tb_mcast_replicator;

	localparam int NUM_MIXED = 360;
	localparam int NUM_BURST = 40;
	localparam int DRAIN_CYCLES = 200;	// Full multicast queue drains in about 140
	localparam int MAX_CYCLES = 20000;	// Whole sequence needs about 4000 at worst

	typedef struct packed {
		logic last;
		rep_pkg::dest_t pid;
		rep_pkg::qid_t qid;
		rep_pkg::rep_desc_t desc;
	} copy_t;

	// Expected outcome of one request
	typedef struct packed {
		logic drop;
		logic ucast;
		rep_pkg::dest_count_t n;
		copy_t [`REP_NDEST-1:0] copies;
	} result_t;

	logic clk;
	logic rst_n;
	logic enq_req;
	logic enq_discard;
	logic enq_allow_mcast;
	rep_pkg::dest_vec_t enq_vec;
	rep_pkg::pri_t enq_pri;
	rep_pkg::rep_desc_t enq_desc;
	logic discard_req;
	rep_pkg::rep_desc_t discard_desc;
	logic rep_enq_req;
	logic rep_enq_ucast;
	logic rep_enq_last;
	rep_pkg::dest_t rep_enq_packet_id;
	rep_pkg::qid_t rep_enq_qid;
	rep_pkg::rep_desc_t rep_enq_desc;

	copy_t ucast_sb[$];
	copy_t mcast_sb[$];
	rep_pkg::rep_desc_t disc_sb[$];
	logic [`REP_BUF_PTR_NBITS-1:0] next_tag;
	logic allow_full_drop;	// Burst phase only
	int burst_drops;
	int cycles = 0;
	integer seed;

	tb_clkgen #(.PERIOD(100), .RESET_CYCLES(16)) clkgen_i (.clk(clk), .rst_n(rst_n));

	mcast_replicator dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.enq_req(enq_req),
		.enq_discard(enq_discard),
		.enq_allow_mcast(enq_allow_mcast),
		.enq_vec(enq_vec),
		.enq_pri(enq_pri),
		.enq_desc(enq_desc),
		.discard_req(discard_req),
		.discard_desc(discard_desc),
		.rep_enq_req(rep_enq_req),
		.rep_enq_ucast(rep_enq_ucast),
		.rep_enq_last(rep_enq_last),
		.rep_enq_packet_id(rep_enq_packet_id),
		.rep_enq_qid(rep_enq_qid),
		.rep_enq_desc(rep_enq_desc)
	);

	function automatic result_t expected_result(input logic discard, input logic allow,
		input rep_pkg::dest_vec_t vec, input rep_pkg::pri_t pri,
		input rep_pkg::rep_desc_t desc);
		result_t res;
		int k;
		res = '0;
		k = 0;
		for (int i = 0; i < `REP_NDEST; i++)
			if (vec[i])
			begin
				res.copies[k].qid = {pri, rep_pkg::dest_t'(i)};	// Ascending destinations
				res.copies[k].pid = rep_pkg::dest_t'(k);
				res.copies[k].desc = desc;
				k++;
			end
		if (k > 0)
			res.copies[k-1].last = 1'b1;
		res.n = rep_pkg::dest_count_t'(k);
		res.ucast = (k == 1);
		res.drop = discard || (k == 0) || (k > 1 && !allow);
		return res;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_copy(input rep_pkg::qid_t exp_qid, input rep_pkg::qid_t got_qid,
		input rep_pkg::dest_t exp_id, input rep_pkg::dest_t got_id,
		input logic exp_last, input logic got_last,
		input rep_pkg::rep_desc_t exp_desc, input rep_pkg::rep_desc_t got_desc);
		if (got_desc !== exp_desc)
			fail_run($sformatf("MISMATCH rep_enq_desc: expected %h got %h", exp_desc, got_desc));
		else if (got_qid !== exp_qid)
			fail_run($sformatf("MISMATCH rep_enq_qid: expected %h got %h", exp_qid, got_qid));
		else if (got_id !== exp_id)
			fail_run($sformatf("MISMATCH rep_enq_packet_id: expected %h got %h", exp_id, got_id));
		else if (got_last !== exp_last)
			fail_run($sformatf("MISMATCH rep_enq_last: expected %h got %h", exp_last, got_last));
	endtask

	task automatic check_discard(input rep_pkg::rep_desc_t exp_desc,
		input rep_pkg::rep_desc_t got_desc);
		if (got_desc !== exp_desc)
			fail_run($sformatf("MISMATCH discard_desc: expected %h got %h", exp_desc, got_desc));
	endtask

	task automatic compare_copy();
		copy_t exp;
		if (rep_enq_ucast && ucast_sb.size() == 0)
			fail_run($sformatf("unicast copy of buf_ptr %h was not expected",
				rep_enq_desc.buf_ptr));
		else if (!rep_enq_ucast && mcast_sb.size() == 0)
			fail_run($sformatf("multicast copy of buf_ptr %h was not expected",
				rep_enq_desc.buf_ptr));
		else
		begin
			exp = rep_enq_ucast ? ucast_sb.pop_front() : mcast_sb.pop_front();
			check_copy(exp.qid, rep_enq_qid, exp.pid, rep_enq_packet_id,
				exp.last, rep_enq_last, exp.desc, rep_enq_desc);
		end
	endtask

	// A full queue drops a whole request, found by its tag
	task automatic drop_by_tag(input rep_pkg::rep_desc_t got);
		rep_pkg::rep_desc_t exp_desc;
		int idx;
		int removed;
		exp_desc = '0;
		idx = 0;
		removed = 0;
		while (idx < mcast_sb.size())
			if (mcast_sb[idx].desc.buf_ptr == got.buf_ptr)
			begin
				exp_desc = mcast_sb[idx].desc;
				mcast_sb.delete(idx);
				removed++;
			end
			else
				idx++;
		if (removed == 0)
			fail_run($sformatf("discard of buf_ptr %h matches no pending request", got.buf_ptr));
		else
		begin
			check_discard(exp_desc, got);
			burst_drops++;
		end
	endtask

	task automatic compare_discard();
		if (disc_sb.size() != 0)
			check_discard(disc_sb.pop_front(), discard_desc);
		else if (allow_full_drop)
			drop_by_tag(discard_desc);
		else
			fail_run($sformatf("discard of buf_ptr %h was not expected", discard_desc.buf_ptr));
	endtask

	task automatic drive_req(input logic discard, input logic allow,
		input rep_pkg::dest_vec_t vec, input rep_pkg::pri_t pri, output int n_copies);
		rep_pkg::rep_desc_t desc;
		result_t res;
		logic [31:0] fill;
		fill = $random(seed);
		desc.buf_ptr = next_tag;
		desc.len = fill[`REP_LEN_NBITS-1:0];
		desc.src_port = fill[16 +: `REP_PORT_NBITS];
		next_tag = next_tag + 1'b1;
		res = expected_result(discard, allow, vec, pri, desc);
		@(posedge clk);
		enq_req <= 1'b1;
		enq_discard <= discard;
		enq_allow_mcast <= allow;
		enq_vec <= vec;
		enq_pri <= pri;
		enq_desc <= desc;
		n_copies = res.drop ? 0 : int'(res.n);
		if (res.drop)
			disc_sb.push_back(desc);
		for (int j = 0; j < n_copies; j++)
			if (res.ucast)
				ucast_sb.push_back(res.copies[j]);
			else
				mcast_sb.push_back(res.copies[j]);
	endtask

	task automatic drive_idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			enq_req <= 1'b0;
		end
	endtask

	// Gap long enough for the fan-out to keep up
	task automatic send_spaced(input logic discard, input logic allow,
		input rep_pkg::dest_vec_t vec, input rep_pkg::pri_t pri);
		int n;
		drive_req(discard, allow, vec, pri, n);
		drive_idle(n + 1);
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		waited = 0;
		while ((ucast_sb.size() != 0 || mcast_sb.size() != 0 || disc_sb.size() != 0)
			&& waited < limit)
		begin
			@(posedge clk);
			waited++;
		end
	endtask

	always @(negedge clk)
		if (rst_n)
		begin
			if (discard_req)
				compare_discard();
			if (rep_enq_req)
				compare_copy();
		end

	always @(posedge clk)
	begin
		if (cycles >= MAX_CYCLES)
			fail_run($sformatf("timeout after %0d cycles with traffic still pending", cycles));
		cycles <= cycles + 1;
	end

	initial
	begin
		int n;
		logic [31:0] rnd;
		rep_pkg::dest_vec_t vec;
		seed = 10;
		next_tag = '0;
		allow_full_drop = 1'b0;
		burst_drops = 0;
		enq_req <= 1'b0;
		enq_discard <= 1'b0;
		enq_allow_mcast <= 1'b0;
		enq_vec <= '0;
		enq_pri <= '0;
		enq_desc <= '0;
		wait (rst_n === 1'b1);
		drive_idle(2);

		for (int d = 0; d < `REP_NDEST; d++)
			send_spaced(1'b0, d[0], rep_pkg::dest_vec_t'(1) << d, rep_pkg::pri_t'(d));

		send_spaced(1'b0, 1'b1, 8'hff, 2'd3);
		send_spaced(1'b0, 1'b1, 8'h81, 2'd1);
		send_spaced(1'b0, 1'b1, 8'h5a, 2'd2);
		send_spaced(1'b0, 1'b1, 8'h03, 2'd0);

		send_spaced(1'b1, 1'b1, 8'h10, 2'd0);	// Discard flag on a unicast
		send_spaced(1'b0, 1'b1, 8'h00, 2'd1);
		send_spaced(1'b0, 1'b0, 8'h06, 2'd2);	// Multicast not allowed
		send_spaced(1'b1, 1'b1, 8'hf0, 2'd3);

		for (int i = 0; i < NUM_MIXED; i++)
		begin
			rnd = $random(seed);
			if (rnd[3:0] < 4'd6)
				vec = rep_pkg::dest_vec_t'(1) << rnd[6:4];
			else if (rnd[3:0] == 4'd13)
				vec = '0;
			else
				vec = rnd[15:8];
			send_spaced(rnd[19:16] == 4'd0, rnd[22:20] != 3'd0, vec, rnd[24:23]);
		end
		wait_drain(DRAIN_CYCLES);

		// Back-to-back full fan-out overruns the multicast queue
		allow_full_drop = 1'b1;
		for (int i = 0; i < NUM_BURST; i++)
			drive_req(1'b0, 1'b1, '1, rep_pkg::pri_t'(i), n);
		drive_idle(1);
		wait_drain(DRAIN_CYCLES);
		allow_full_drop = 1'b0;
		if (burst_drops == 0)
			fail_run("burst of full multicast requests caused no queue-full discard");

		drive_idle(10);
		if (ucast_sb.size() != 0 || mcast_sb.size() != 0 || disc_sb.size() != 0)
			fail_run("expected copies or discards still pending at the end of the run");
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: mcast_replicator.f
+incdir+verilog
verilog/rep_pkg.sv
verilog/rep_if.sv
verilog/rep_fifo.sv
verilog/rep_enq_classifier.sv
verilog/rep_enq_queue.sv
verilog/rep_fanout.sv
verilog/mcast_replicator.sv
tb/tb_clkgen.sv
tb/tb_mcast_replicator.sv
